// File: rtl/mem_arb_pkg.sv
package mem_arb_pkg;

  // completion buffer sizing
  localparam int num_cb_entry = 16;
  localparam int cb_idx_w = $clog2(num_cb_entry);

  // generic bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  // one enable per byte lane
  localparam int be_w = data_w / 8;
  // low address bits that select a byte inside a word
  localparam int byte_off_w = $clog2(be_w);

  // data ram depth, in words
  localparam int ram_words = 256;
  localparam int ram_idx_w = $clog2(ram_words);

  // index into the completion buffer
  typedef logic [cb_idx_w-1:0] cb_idx_t;

  // request side of the generic bus
  // pending while ren or wen is high, held steady until busy drops
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              ren;
    logic              wen;
    logic [data_w-1:0] wdata;
    logic [be_w-1:0]   byte_en;
  } bus_req_t;

  // response side of the generic bus
  // busy low for exactly one cycle per transaction
  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              busy;
  } bus_rsp_t;

  // what a port sees while it does not own the bus
  localparam bus_rsp_t rsp_idle = '{rdata: '0, busy: 1'b1};

  // current owner of the shared memory bus
  typedef enum logic [1:0] {
    grant_none,
    grant_scalar,
    grant_vector
  } grant_t;

endpackage

// File: rtl/completion_buffer.sv
module completion_buffer (
  input  logic                 CLK,
  input  logic                 arst_n,
  // allocation in program order
  input  logic                 alloc,
  output mem_arb_pkg::cb_idx_t alloc_index,
  output logic                 cb_full,
  // completion from the memory side
  input  logic                 mem_complete,
  input  mem_arb_pkg::cb_idx_t mem_complete_index,
  // completion of non-memory instructions
  input  logic                 ext_complete,
  input  mem_arb_pkg::cb_idx_t ext_complete_index,
  // oldest live entry
  output mem_arb_pkg::cb_idx_t cb_tail_index
);
  import mem_arb_pkg::*;

  cb_idx_t                 head_q;
  cb_idx_t                 tail_q;
  logic [cb_idx_w:0]       count_q;
  logic [num_cb_entry-1:0] done_q;
  logic                    cb_empty;
  logic                    do_alloc;
  logic                    do_retire;

  // count runs 0..num_cb_entry, one bit wider than an index
  assign cb_full  = (count_q == (cb_idx_w + 1)'(num_cb_entry));
  assign cb_empty = (count_q == '0);

  // alloc while full is dropped
  assign do_alloc = alloc && !cb_full;

  // retire only the tail, and only once it is done
  assign do_retire = !cb_empty && done_q[tail_q];

  // head is the index handed out this cycle
  assign alloc_index   = head_q;
  assign cb_tail_index = tail_q;

  // head pointer, wraps naturally at num_cb_entry
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      head_q <= '0;
    end else if (do_alloc) begin
      head_q <= head_q + cb_idx_t'(1);
    end
  end

  // tail pointer, one step per cycle at most
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tail_q <= '0;
    end else if (do_retire) begin
      tail_q <= tail_q + cb_idx_t'(1);
    end
  end

  // occupancy
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else begin
      case ({do_alloc, do_retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // done bits
  // both strobes may land in one cycle on different entries
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      done_q <= '0;
    end else begin
      if (mem_complete) begin
        done_q[mem_complete_index] <= 1'b1;
      end
      if (ext_complete) begin
        done_q[ext_complete_index] <= 1'b1;
      end
      // retiring entry leaves clean for its next allocation
      if (do_retire) begin
        done_q[tail_q] <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/memory_arbiter.sv
module memory_arbiter (
  input  logic                  CLK,
  input  logic                  arst_n,
  // requesters
  input  mem_arb_pkg::bus_req_t scalar_req,
  input  mem_arb_pkg::bus_req_t vector_req,
  input  mem_arb_pkg::cb_idx_t  scalar_cb_index,
  input  mem_arb_pkg::cb_idx_t  vector_cb_index,
  // oldest live completion buffer entry
  input  mem_arb_pkg::cb_idx_t  cb_tail_index,
  // responses back to the requesters
  output mem_arb_pkg::bus_rsp_t scalar_rsp,
  output mem_arb_pkg::bus_rsp_t vector_rsp,
  // shared memory bus
  output mem_arb_pkg::bus_req_t mem_req,
  input  mem_arb_pkg::bus_rsp_t mem_rsp,
  // end of the granted transaction
  output logic                  mem_complete,
  output mem_arb_pkg::cb_idx_t  mem_complete_index
);
  import mem_arb_pkg::*;

  logic    scalar_pend;
  logic    vector_pend;
  cb_idx_t scalar_dist;
  cb_idx_t vector_dist;
  grant_t  grant_q;
  grant_t  grant_sel;

  assign scalar_pend = scalar_req.ren | scalar_req.wen;
  assign vector_pend = vector_req.ren | vector_req.wen;

  // age = distance from the tail, modulo num_cb_entry
  // zero means the request belongs to the oldest entry
  assign scalar_dist = scalar_cb_index - cb_tail_index;
  assign vector_dist = vector_cb_index - cb_tail_index;

  // owner for this cycle
  always_comb begin
    grant_sel = grant_none;
    if (grant_q != grant_none) begin
      // transaction in flight keeps the bus
      grant_sel = grant_q;
    end else if (scalar_pend && vector_pend) begin
      // older wins, tie goes to vector
      if (scalar_dist < vector_dist) begin
        grant_sel = grant_scalar;
      end else begin
        grant_sel = grant_vector;
      end
    end else if (scalar_pend) begin
      grant_sel = grant_scalar;
    end else if (vector_pend) begin
      grant_sel = grant_vector;
    end
  end

  // grant lock
  // set on the edge that starts the transaction
  // cleared on the edge that closes the busy-low cycle
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      grant_q <= grant_none;
    end else if (grant_q == grant_none) begin
      grant_q <= grant_sel;
    end else if (!mem_rsp.busy) begin
      grant_q <= grant_none;
    end
  end

  // bus steering
  always_comb begin
    mem_req            = '0;
    scalar_rsp         = rsp_idle;
    vector_rsp         = rsp_idle;
    mem_complete_index = '0;
    case (grant_sel)
      grant_scalar: begin
        mem_req            = scalar_req;
        scalar_rsp         = mem_rsp;
        mem_complete_index = scalar_cb_index;
      end
      grant_vector: begin
        mem_req            = vector_req;
        vector_rsp         = mem_rsp;
        mem_complete_index = vector_cb_index;
      end
      default: begin
        // bus idle, ports stay busy
        mem_req = '0;
      end
    endcase
  end

  // one pulse per finished transaction
  assign mem_complete = (grant_sel != grant_none) && !mem_rsp.busy;

endmodule

// File: rtl/data_ram.sv
module data_ram (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  mem_arb_pkg::bus_req_t mem_req,
  output mem_arb_pkg::bus_rsp_t mem_rsp
);
  import mem_arb_pkg::*;

  logic [data_w-1:0]    mem_q [ram_words];
  logic [7:0]           lfsr_q;
  logic                 lfsr_fb;
  logic                 active_q;
  logic [2:0]           wait_q;
  logic                 req_pend;
  logic                 xfer_end;
  logic [ram_idx_w-1:0] word_idx;

  assign req_pend = mem_req.ren | mem_req.wen;

  // word address, wraps at ram_words
  assign word_idx = mem_req.addr[byte_off_w +: ram_idx_w];

  // last cycle of a transaction
  assign xfer_end = active_q && (wait_q == '0);

  // x^8 + x^6 + x^5 + x^4 + 1, free running
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      lfsr_q <= 8'hb5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  // wait state counter
  // idle -> load 1..4 -> count down -> one busy-low cycle -> idle
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      active_q <= 1'b0;
      wait_q   <= '0;
    end else if (!active_q) begin
      if (req_pend) begin
        active_q <= 1'b1;
        wait_q   <= {1'b0, lfsr_q[1:0]} + 3'd1;
      end
    end else if (wait_q != '0) begin
      wait_q <= wait_q - 3'd1;
    end else begin
      active_q <= 1'b0;
    end
  end

  // storage, zeroed at reset
  // write lands on the edge closing the busy-low cycle
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ram_words; i++) begin
        mem_q[i] <= '0;
      end
    end else if (xfer_end && mem_req.wen) begin
      for (int b = 0; b < be_w; b++) begin
        if (mem_req.byte_en[b]) begin
          mem_q[word_idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // busy high except in the final cycle
  // read data only valid then, zero otherwise
  always_comb begin
    mem_rsp.busy  = !xfer_end;
    mem_rsp.rdata = '0;
    if (xfer_end && mem_req.ren) begin
      mem_rsp.rdata = mem_q[word_idx];
    end
  end

endmodule

// File: rtl/mem_subsys_top.sv
module mem_subsys_top (
  input  logic                  CLK,
  input  logic                  arst_n,
  // scalar load/store path
  input  mem_arb_pkg::bus_req_t scalar_req,
  input  mem_arb_pkg::cb_idx_t  scalar_cb_index,
  output mem_arb_pkg::bus_rsp_t scalar_rsp,
  // vector load/store path
  input  mem_arb_pkg::bus_req_t vector_req,
  input  mem_arb_pkg::cb_idx_t  vector_cb_index,
  output mem_arb_pkg::bus_rsp_t vector_rsp,
  // completion buffer allocation
  input  logic                  alloc,
  output mem_arb_pkg::cb_idx_t  alloc_index,
  output logic                  cb_full,
  // non-memory completion
  input  logic                  ext_complete,
  input  mem_arb_pkg::cb_idx_t  ext_complete_index,
  output mem_arb_pkg::cb_idx_t  cb_tail_index
);
  import mem_arb_pkg::*;

  // arbiter <-> ram
  bus_req_t mem_req;
  bus_rsp_t mem_rsp;
  // arbiter -> completion buffer
  logic     mem_complete;
  cb_idx_t  mem_complete_index;

  completion_buffer u_completion_buffer (
    .CLK                (CLK),
    .arst_n             (arst_n),
    .alloc              (alloc),
    .alloc_index        (alloc_index),
    .cb_full            (cb_full),
    .mem_complete       (mem_complete),
    .mem_complete_index (mem_complete_index),
    .ext_complete       (ext_complete),
    .ext_complete_index (ext_complete_index),
    .cb_tail_index      (cb_tail_index)
  );

  // tail also feeds the age compare
  memory_arbiter u_memory_arbiter (
    .CLK                (CLK),
    .arst_n             (arst_n),
    .scalar_req         (scalar_req),
    .vector_req         (vector_req),
    .scalar_cb_index    (scalar_cb_index),
    .vector_cb_index    (vector_cb_index),
    .cb_tail_index      (cb_tail_index),
    .scalar_rsp         (scalar_rsp),
    .vector_rsp         (vector_rsp),
    .mem_req            (mem_req),
    .mem_rsp            (mem_rsp),
    .mem_complete       (mem_complete),
    .mem_complete_index (mem_complete_index)
  );

  data_ram u_data_ram (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

// File: sim/memory_arbiter_sva.sv
module memory_arbiter_sva (
  input logic                  CLK,
  input logic                  arst_n,
  input mem_arb_pkg::grant_t   grant_q,
  input mem_arb_pkg::bus_req_t mem_req,
  input mem_arb_pkg::bus_rsp_t mem_rsp,
  input mem_arb_pkg::bus_rsp_t scalar_rsp,
  input mem_arb_pkg::bus_rsp_t vector_rsp,
  input logic                  mem_complete
);
  timeunit 1ns;
  timeprecision 100ps;
  import mem_arb_pkg::*;

  // completion only closes a locked transaction
  complete_on_end: assert property (
    @(posedge CLK) disable iff (!arst_n)
      mem_complete |-> (!mem_rsp.busy && grant_q != grant_none)
  ) else $error("mem_complete raised outside a locked transaction");

  // locked owner and its request hold while the ram is busy
  grant_stable: assert property (
    @(posedge CLK) disable iff (!arst_n)
      (grant_q != grant_none && mem_rsp.busy) |=> ($stable(grant_q) && $stable(mem_req))
  ) else $error("grant or granted request changed during a transaction");

  // a release is always followed by a cycle with both ports busy
  one_port_done: assert property (
    @(posedge CLK) disable iff (!arst_n)
      (!scalar_rsp.busy || !vector_rsp.busy) |=> (scalar_rsp.busy && vector_rsp.busy)
  ) else $error("a port saw busy low on two cycles in a row");

endmodule

bind memory_arbiter memory_arbiter_sva u_memory_arbiter_sva (
  .CLK          (CLK),
  .arst_n       (arst_n),
  .grant_q      (grant_q),
  .mem_req      (mem_req),
  .mem_rsp      (mem_rsp),
  .scalar_rsp   (scalar_rsp),
  .vector_rsp   (vector_rsp),
  .mem_complete (mem_complete)
);

// File: sim/mem_subsys_tb.sv
module mem_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_arb_pkg::*;

  logic     CLK;
  logic     arst_n;
  bus_req_t scalar_req;
  bus_req_t vector_req;
  cb_idx_t  scalar_cb_index;
  cb_idx_t  vector_cb_index;
  bus_rsp_t scalar_rsp;
  bus_rsp_t vector_rsp;
  logic     alloc;
  cb_idx_t  alloc_index;
  logic     cb_full;
  logic     ext_complete;
  cb_idx_t  ext_complete_index;
  cb_idx_t  cb_tail_index;

  // reference model, ram covers the 16 test words only
  logic [data_w-1:0]       model_ram [16];
  logic [num_cb_entry-1:0] model_done;
  cb_idx_t                 model_head;
  cb_idx_t                 model_tail;
  int                      model_count;
  // work lists of the current round
  cb_idx_t scalar_q [$];
  cb_idx_t vector_q [$];
  cb_idx_t ext_q [$];
  grant_t  first_done;
  int      n_issued;
  int      n_xfer;

  mem_subsys_top u_mem_subsys_top (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // every busy-low cycle seen on a port is one response
  always @(negedge CLK) begin
    if (arst_n) begin
      if (!scalar_rsp.busy) begin
        n_xfer++;
      end
      if (!vector_rsp.busy) begin
        n_xfer++;
      end
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected rdata=%h busy=%b actual rdata=%h busy=%b",
                              name, exp.rdata, exp.busy, act.rdata, act.busy));
    end
  endtask

  task automatic check_index(input string name, input cb_idx_t exp, input cb_idx_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_grant(input string name, input grant_t exp, input grant_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic drive_port(input bit is_vec, input bus_req_t req, input cb_idx_t idx);
    if (is_vec) begin
      vector_req      = req;
      vector_cb_index = idx;
    end else begin
      scalar_req      = req;
      scalar_cb_index = idx;
    end
  endtask

  // one transaction, entered and left just after a rising edge
  task automatic run_mem_op(input bit is_vec, input cb_idx_t idx);
    bus_req_t req;
    bus_rsp_t rsp;
    bus_rsp_t exp;
    int       word;
    int       waited;
    string    name;
    word        = $urandom_range(15);
    req         = '0;
    req.addr    = addr_w'(word * 4);
    req.wen     = 1'($urandom_range(1));
    req.ren     = !req.wen;
    req.wdata   = $urandom();
    req.byte_en = be_w'($urandom_range(15));
    name        = is_vec ? "vector" : "scalar";
    exp         = '{rdata: '0, busy: 1'b1};
    waited      = 0;
    drive_port(is_vec, req, idx);
    do begin
      @(negedge CLK);
      rsp = is_vec ? vector_rsp : scalar_rsp;
      if (rsp.busy) begin
        // waiting port sees busy with zero data
        check_rsp({name, " waiting"}, exp, rsp);
        waited++;
        if (waited > 200) begin
          stop_on_error({"timeout, the ", name, " port got no response in 200 cycles"});
        end
      end
    end while (rsp.busy);
    if (req.ren) begin
      exp = '{rdata: model_ram[word], busy: 1'b0};
      check_rsp({name, " read"}, exp, rsp);
    end else begin
      for (int b = 0; b < be_w; b++) begin
        if (req.byte_en[b]) begin
          model_ram[word][8*b +: 8] = req.wdata[8*b +: 8];
        end
      end
    end
    model_done[idx] = 1'b1;
    if (first_done == grant_none) begin
      first_done = is_vec ? grant_vector : grant_scalar;
    end
    @(posedge CLK);
    #1;
    drive_port(is_vec, '0, idx);
    // random idle gap between ops
    repeat ($urandom_range(2)) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // each port works through its own entries in program order
  task automatic run_port(input bit is_vec);
    cb_idx_t idx;
    @(posedge CLK);
    #1;
    while ((is_vec ? vector_q.size() : scalar_q.size()) != 0) begin
      if (is_vec) begin
        idx = vector_q.pop_front();
      end else begin
        idx = scalar_q.pop_front();
      end
      run_mem_op(is_vec, idx);
    end
  endtask

  // non-memory ops finish in random order
  task automatic run_ext();
    int k;
    while (ext_q.size() != 0) begin
      repeat (1 + $urandom_range(3)) @(posedge CLK);
      #1;
      k = $urandom_range(ext_q.size() - 1);
      ext_complete       = 1'b1;
      ext_complete_index = ext_q[k];
      model_done[ext_q[k]] = 1'b1;
      ext_q.delete(k);
      @(posedge CLK);
      #1;
      ext_complete = 1'b0;
    end
  endtask

  // tie round: first entry non-memory, second shared by both ports
  task automatic alloc_entries(input int n, input bit tie);
    int kind;
    for (int i = 0; i < n; i++) begin
      alloc = 1'b1;
      @(negedge CLK);
      check_index("alloc_index", model_head, alloc_index);
      check_flag("cb_full", model_count == num_cb_entry, cb_full);
      // alloc while full must leave the head alone
      if (model_count < num_cb_entry) begin
        kind = tie ? (i == 0 ? 0 : 3) : $urandom_range(2);
        case (kind)
          0: ext_q.push_back(model_head);
          1: scalar_q.push_back(model_head);
          2: vector_q.push_back(model_head);
          default: begin
            scalar_q.push_back(model_head);
            vector_q.push_back(model_head);
          end
        endcase
        n_issued    = n_issued + (kind == 3 ? 2 : (kind == 0 ? 0 : 1));
        model_head  = model_head + cb_idx_t'(1);
        model_count = model_count + 1;
      end
      @(posedge CLK);
      #1;
    end
    alloc = 1'b0;
  endtask

  task automatic run_round(input int n, input bit tie);
    grant_t  exp_first;
    cb_idx_t s_dist;
    cb_idx_t v_dist;
    bit      both;
    int      waited;
    alloc_entries(n, tie);
    both      = (scalar_q.size() != 0) && (vector_q.size() != 0);
    exp_first = grant_none;
    if (both) begin
      // older = closer to the tail, equal distance goes to vector
      s_dist    = scalar_q[0] - model_tail;
      v_dist    = vector_q[0] - model_tail;
      exp_first = (s_dist < v_dist) ? grant_scalar : grant_vector;
    end
    first_done = grant_none;
    if (tie) begin
      // tail entry held back until both ports are through
      fork
        run_port(1'b0);
        run_port(1'b1);
      join
      run_ext();
    end else begin
      fork
        run_port(1'b0);
        run_port(1'b1);
        run_ext();
      join
    end
    if (both) begin
      check_grant("first completion", exp_first, first_done);
    end
    // in-order retirement of the model
    while (model_count != 0 && model_done[model_tail]) begin
      model_done[model_tail] = 1'b0;
      model_tail  = model_tail + cb_idx_t'(1);
      model_count = model_count - 1;
    end
    waited = 0;
    @(negedge CLK);
    while (cb_tail_index != model_tail) begin
      waited++;
      if (waited > 200) begin
        stop_on_error("timeout, the completion buffer tail never reached the oldest live entry");
      end
      @(negedge CLK);
    end
    // tail must stay put once idle
    repeat (2) @(negedge CLK);
    check_index("cb_tail_index", model_tail, cb_tail_index);
    check_flag("cb_full idle", model_count == num_cb_entry, cb_full);
    @(posedge CLK);
    #1;
  endtask

  initial begin
    bus_rsp_t idle_rsp;
    void'($urandom(56486));
    idle_rsp           = '{rdata: '0, busy: 1'b1};
    arst_n             = 1'b0;
    alloc              = 1'b0;
    ext_complete       = 1'b0;
    ext_complete_index = '0;
    scalar_req         = '0;
    vector_req         = '0;
    scalar_cb_index    = '0;
    vector_cb_index    = '0;
    model_ram          = '{default: '0};
    model_done         = '0;
    model_head         = '0;
    model_tail         = '0;
    model_count        = 0;
    n_issued           = 0;
    n_xfer             = 0;
    repeat (16) @(posedge CLK);
    #1;
    arst_n = 1'b1;
    @(negedge CLK);
    check_rsp("scalar after reset", idle_rsp, scalar_rsp);
    check_rsp("vector after reset", idle_rsp, vector_rsp);
    check_index("tail after reset", '0, cb_tail_index);
    check_flag("cb_full after reset", 1'b0, cb_full);
    @(posedge CLK);
    #1;
    // fill to the brim, one extra alloc is dropped
    run_round(num_cb_entry + 1, 1'b0);
    for (int r = 0; r < 40; r++) begin
      run_round($urandom_range(12, 1), 1'b0);
    end
    run_round(2, 1'b1);
    run_round(num_cb_entry + 1, 1'b0);
    // the last dropped alloc must not have moved the head
    @(negedge CLK);
    check_index("final head", model_head, alloc_index);
    if (n_xfer == n_issued) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_on_error("the ports saw a different number of responses than requests issued");
    end
  end

endmodule

// File: project.f
rtl/mem_arb_pkg.sv
rtl/completion_buffer.sv
rtl/memory_arbiter.sv
rtl/data_ram.sv
rtl/mem_subsys_top.sv
sim/memory_arbiter_sva.sv
sim/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
